// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_mycpu_mem
FILELIST   ?= filelist.f
COMMON     ?= --timing --assert --top-module $(TOP)
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary -j 0
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON) -f $(FILELIST)

# an aborted run counts as a failure in the log
sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
rtl/cpu_mem_pkg.sv
rtl/addr_map.sv
rtl/icache.sv
rtl/fetch_unit.sv
rtl/mycpu_mem.sv
sim/mycpu_mem_chk.sv
sim/tb_mycpu_mem.sv

// ==== rtl/addr_map.sv ====
`timescale 1ns/1ns

module addr_map (
  input  logic [31:0] vaddr,
  output logic [31:0] paddr,
  output logic        cached
);

  logic [2:0] seg;      // top three address bits
  logic       is_kseg0; // 0x8000_0000 .. 0x9fff_ffff
  logic       is_kseg1; // 0xa000_0000 .. 0xbfff_ffff

  assign seg      = vaddr[31:29];
  assign is_kseg0 = (seg == cpu_mem_pkg::KSEG0_BASE[31:29]);
  assign is_kseg1 = (seg == cpu_mem_pkg::KSEG1_BASE[31:29]);

  // unmapped segments drop to the low 512 MB
  // kuseg and kseg2 would go through a TLB, here they pass as is
  always_comb begin
    if (is_kseg0 || is_kseg1) begin
      paddr = vaddr & cpu_mem_pkg::PHYS_MASK; // clear segment bits
    end else begin
      paddr = vaddr; // no translation
    end
  end

  assign cached = ~is_kseg1; // only kseg1 bypasses caches

endmodule

// ==== rtl/cpu_mem_pkg.sv ====
package cpu_mem_pkg;

  localparam logic [31:0] RESET_PC   = 32'hbfc0_0000; // boot vector, kseg1
  localparam logic [31:0] KSEG0_BASE = 32'h8000_0000; // cached, unmapped
  localparam logic [31:0] KSEG1_BASE = 32'ha000_0000; // uncached, unmapped
  localparam logic [31:0] PHYS_MASK  = 32'h1fff_ffff; // strips segment bits

  localparam int DEF_SETS       = 64; // default icache sets
  localparam int DEF_LINE_WORDS = 4;  // default words per line

  // fetch unit -> icache
  typedef struct packed {
    logic        req;
    logic [31:0] pc;     // virtual
    logic        cached; // from segment decode
  } fetch_req_t;

  // icache -> fetch unit
  typedef struct packed {
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata_1;   // word at pc
    logic [31:0] rdata_2;   // word at pc+4
    logic        second_ok; // rdata_2 usable, valid with data_ok
  } fetch_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr_0;
    logic [31:0] instr_1;
    logic        pair; // instr_1 valid
  } fetch_bundle_t;

  // sram-like bus, request side
  typedef struct packed {
    logic        req;
    logic        wr;
    logic [1:0]  size;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        addr_ok;
    logic        data_ok;
  } mem_rsp_t;

  // core data access, virtual address
  typedef struct packed {
    logic        req;
    logic        wr;
    logic [1:0]  size;
    logic [31:0] addr;
    logic [31:0] wdata;
  } data_req_t;

endpackage

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       redirect,
  input  logic [31:0]                redirect_pc,
  input  logic                       fetch_hold,
  output cpu_mem_pkg::fetch_req_t    cache_req,
  input  cpu_mem_pkg::fetch_rsp_t    cache_rsp,
  output cpu_mem_pkg::fetch_bundle_t fetch_bundle
);

  logic [31:0] pc_q;        // pc of the next or current fetch
  logic        inflight_q;  // accepted, waiting for data_ok
  logic        squash_q;    // in-flight answer belongs to an old pc
  logic        valid_q;
  logic [31:0] bundle_pc_q;
  logic [31:0] instr_0_q;
  logic [31:0] instr_1_q;
  logic        pair_q;

  logic        issue;
  logic        accepted;
  logic        returned;
  logic        deliver;
  logic        kill;
  logic [31:0] pc_step;

  assign issue    = ~inflight_q & ~fetch_hold; // one fetch at a time
  assign accepted = issue & cache_rsp.addr_ok;
  assign returned = inflight_q & cache_rsp.data_ok;
  assign deliver  = returned & ~squash_q & ~redirect; // drop stale answers
  assign pc_step  = cache_rsp.second_ok ? 32'd8 : 32'd4;

  // redirect hits a fetch already on its way
  assign kill = redirect & (accepted | (inflight_q & ~returned));

  assign cache_req.req    = issue;
  assign cache_req.pc     = pc_q;
  assign cache_req.cached = 1'b1; // core never forces uncached, top refines

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q       <= cpu_mem_pkg::RESET_PC;
      inflight_q <= 1'b0;
      squash_q   <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      valid_q <= deliver; // one cycle pulse

      if (accepted) begin
        inflight_q <= 1'b1;
      end else if (returned) begin
        inflight_q <= 1'b0;
      end

      if (kill) begin
        squash_q <= 1'b1;
      end else if (returned) begin
        squash_q <= 1'b0;
      end

      if (redirect) begin
        pc_q <= redirect_pc; // wins over advance
      end else if (deliver) begin
        pc_q <= pc_q + pc_step;
      end
    end
  end

  // fetched pair, registered
  always_ff @(posedge clk) begin
    if (deliver) begin
      bundle_pc_q <= pc_q;
      instr_0_q   <= cache_rsp.rdata_1;
      instr_1_q   <= cache_rsp.second_ok ? cache_rsp.rdata_2 : 32'd0;
      pair_q      <= cache_rsp.second_ok;
    end
  end

  assign fetch_bundle = '{
    valid:   valid_q,
    pc:      bundle_pc_q,
    instr_0: instr_0_q,
    instr_1: instr_1_q,
    pair:    pair_q
  };

endmodule

// ==== rtl/icache.sv ====
`timescale 1ns/1ns

module icache #(
  parameter int SETS       = cpu_mem_pkg::DEF_SETS,
  parameter int LINE_WORDS = cpu_mem_pkg::DEF_LINE_WORDS
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  cpu_mem_pkg::fetch_req_t cpu_req,
  output cpu_mem_pkg::fetch_rsp_t cpu_rsp,
  output cpu_mem_pkg::mem_req_t   mem_req,
  input  cpu_mem_pkg::mem_rsp_t   mem_rsp
);

  localparam int OFF_W   = $clog2(LINE_WORDS); // word offset bits
  localparam int IDX_W   = $clog2(SETS);       // set index bits
  localparam int IDX_LSB = 2 + OFF_W;
  localparam int TAG_LSB = IDX_LSB + IDX_W;
  localparam int TAG_W   = 32 - TAG_LSB;

  typedef enum logic [1:0] {
    ST_IDLE,   // waiting for a fetch
    ST_LOOKUP, // tag compare or answer
    ST_REFILL, // line fill from word 0
    ST_BYPASS  // single uncached word
  } state_t;

  state_t            state_q;
  logic [31:0]       req_pc_q;      // latched virtual pc
  logic              req_cached_q;  // latched cached flag
  logic              outstanding_q; // one bus word in flight
  logic              byp_done_q;    // bypass word captured
  logic [31:0]       byp_word_q;
  logic [OFF_W-1:0]  fill_cnt_q;    // next word of the line

  logic [TAG_W-1:0]  tag_ram [SETS];
  logic [SETS-1:0]   valid_q;
  logic [31:0]       data_ram [SETS][LINE_WORDS];

  logic [31:0]       line_paddr;
  logic [IDX_W-1:0]  idx;
  logic [OFF_W-1:0]  off;
  logic [OFF_W-1:0]  off_nxt;
  logic [TAG_W-1:0]  tag;
  logic              use_cache;
  logic              hit;
  logic              last_word;
  logic              bus_accept;
  logic              bus_return;
  logic              refill_last;

  // physical view of the latched pc
  addr_map u_line_map (
    .vaddr  (req_pc_q),
    .paddr  (line_paddr),
    .cached ()
  );

  assign idx     = line_paddr[IDX_LSB +: IDX_W];
  assign off     = line_paddr[2 +: OFF_W];
  assign off_nxt = off + OFF_W'(1); // wraps on last word, masked by second_ok
  assign tag     = line_paddr[TAG_LSB +: TAG_W];

  assign use_cache   = req_cached_q; // segment decode done at the top
  assign hit         = valid_q[idx] & (tag_ram[idx] == tag);
  assign last_word   = (off == OFF_W'(LINE_WORDS - 1)); // pc+4 leaves the line
  assign bus_accept  = mem_req.req & mem_rsp.addr_ok;
  assign bus_return  = outstanding_q & mem_rsp.data_ok;
  assign refill_last = (fill_cnt_q == OFF_W'(LINE_WORDS - 1));

  // core side answer
  always_comb begin
    cpu_rsp.addr_ok   = (state_q == ST_IDLE) & cpu_req.req; // accept only when idle
    cpu_rsp.data_ok   = 1'b0;
    cpu_rsp.rdata_1   = data_ram[idx][off];
    cpu_rsp.rdata_2   = data_ram[idx][off_nxt];
    cpu_rsp.second_ok = 1'b0;
    if (state_q == ST_LOOKUP) begin
      if (use_cache) begin
        cpu_rsp.data_ok   = hit;
        cpu_rsp.second_ok = hit & ~last_word; // pair stays inside the line
      end else begin
        cpu_rsp.data_ok = byp_done_q;
        cpu_rsp.rdata_1 = byp_word_q;
        cpu_rsp.rdata_2 = '0; // never paired
      end
    end
  end

  // memory side request, read only
  always_comb begin
    mem_req.req   = ~outstanding_q & ((state_q == ST_REFILL) | (state_q == ST_BYPASS));
    mem_req.wr    = 1'b0;
    mem_req.size  = 2'b10; // full word
    mem_req.wdata = '0;
    if (state_q == ST_REFILL) begin
      mem_req.addr = {line_paddr[31:IDX_LSB], fill_cnt_q, 2'b00}; // walk the line
    end else begin
      mem_req.addr = {line_paddr[31:2], 2'b00}; // just the fetched word
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q       <= ST_IDLE;
      outstanding_q <= 1'b0;
      byp_done_q    <= 1'b0;
      fill_cnt_q    <= '0;
      valid_q       <= '0;
    end else begin
      if (bus_accept) begin
        outstanding_q <= 1'b1;
      end else if (bus_return) begin
        outstanding_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (cpu_req.req) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (use_cache) begin
            if (hit) begin
              state_q <= ST_IDLE; // answered this cycle
            end else begin
              state_q      <= ST_REFILL;
              valid_q[idx] <= 1'b0; // line is being replaced
              fill_cnt_q   <= '0;
            end
          end else if (byp_done_q) begin
            state_q    <= ST_IDLE;
            byp_done_q <= 1'b0;
          end else begin
            state_q <= ST_BYPASS;
          end
        end
        ST_REFILL: begin
          if (bus_return) begin
            fill_cnt_q <= fill_cnt_q + OFF_W'(1);
            if (refill_last) begin
              valid_q[idx] <= 1'b1;
              state_q      <= ST_LOOKUP; // replay as a hit
            end
          end
        end
        ST_BYPASS: begin
          if (bus_return) begin
            byp_done_q <= 1'b1;
            state_q    <= ST_LOOKUP;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // arrays and payload
  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && cpu_req.req) begin
      req_pc_q     <= cpu_req.pc;
      req_cached_q <= cpu_req.cached;
    end
    if ((state_q == ST_LOOKUP) && use_cache && !hit) begin
      tag_ram[idx] <= tag; // valid comes at end of fill
    end
    if ((state_q == ST_REFILL) && bus_return) begin
      data_ram[idx][fill_cnt_q] <= mem_rsp.rdata;
    end
    if ((state_q == ST_BYPASS) && bus_return) begin
      byp_word_q <= mem_rsp.rdata; // arrays untouched
    end
  end

endmodule

// ==== rtl/mycpu_mem.sv ====
`timescale 1ns/1ns

module mycpu_mem #(
  parameter int SETS       = cpu_mem_pkg::DEF_SETS,
  parameter int LINE_WORDS = cpu_mem_pkg::DEF_LINE_WORDS
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       redirect,
  input  logic [31:0]                redirect_pc,
  input  logic                       fetch_hold,
  output cpu_mem_pkg::fetch_bundle_t fetch_bundle,
  output cpu_mem_pkg::mem_req_t      inst_bus,
  input  cpu_mem_pkg::mem_rsp_t      inst_rsp,
  input  cpu_mem_pkg::data_req_t     data_in,
  output cpu_mem_pkg::mem_req_t      data_bus,
  input  cpu_mem_pkg::mem_rsp_t      data_rsp,
  output cpu_mem_pkg::mem_rsp_t      data_out
);

  cpu_mem_pkg::fetch_req_t core_req;  // straight from the fetch unit
  cpu_mem_pkg::fetch_req_t cache_req; // with segment cached flag
  cpu_mem_pkg::fetch_rsp_t cache_rsp;
  logic                    fetch_cached;
  logic [31:0]             data_paddr;

  fetch_unit u_fetch (
    .clk          (clk),
    .arst_n       (arst_n),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .fetch_hold   (fetch_hold),
    .cache_req    (core_req),
    .cache_rsp    (cache_rsp),
    .fetch_bundle (fetch_bundle)
  );

  // only the cached flag is needed on the fetch side
  addr_map u_fetch_map (
    .vaddr  (core_req.pc),
    .paddr  (),
    .cached (fetch_cached)
  );

  assign cache_req = '{
    req:    core_req.req,
    pc:     core_req.pc,
    cached: fetch_cached
  };

  icache #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) u_icache (
    .clk     (clk),
    .arst_n  (arst_n),
    .cpu_req (cache_req),
    .cpu_rsp (cache_rsp),
    .mem_req (inst_bus),
    .mem_rsp (inst_rsp)
  );

  // data side stays uncached, address translation only
  addr_map u_data_map (
    .vaddr  (data_in.addr),
    .paddr  (data_paddr),
    .cached ()
  );

  assign data_bus = '{
    req:   data_in.req,
    wr:    data_in.wr,
    size:  data_in.size,
    addr:  data_paddr, // physical
    wdata: data_in.wdata
  };

  assign data_out = data_rsp; // response passes unchanged

endmodule

// ==== sim/mycpu_mem_chk.sv ====
`timescale 1ns/1ns

module mycpu_mem_chk (
  input logic                       clk,
  input logic                       arst_n,
  input cpu_mem_pkg::mem_req_t      inst_bus,
  input cpu_mem_pkg::mem_rsp_t      inst_rsp,
  input cpu_mem_pkg::fetch_bundle_t fetch_bundle
);

  // sram-like rule, a waiting request keeps req and addr
  property req_held;
    @(posedge clk) disable iff (!arst_n)
      inst_bus.req && !inst_rsp.addr_ok |=> inst_bus.req && $stable(inst_bus.addr);
  endproperty

  property no_valid_in_reset;
    @(posedge clk) !arst_n |-> !fetch_bundle.valid;
  endproperty

  // uncached fetch gives one word only
  property no_pair_kseg1;
    @(posedge clk) disable iff (!arst_n)
      fetch_bundle.valid && (fetch_bundle.pc[31:29] == cpu_mem_pkg::KSEG1_BASE[31:29])
      |-> !fetch_bundle.pair;
  endproperty

  a_req_held: assert property (req_held)
    else $error("inst_bus req dropped or addr changed before addr_ok");
  a_no_valid_in_reset: assert property (no_valid_in_reset)
    else $error("fetch_bundle valid while in reset");
  a_no_pair_kseg1: assert property (no_pair_kseg1)
    else $error("paired bundle from a kseg1 pc");

endmodule

bind mycpu_mem mycpu_mem_chk u_chk (
  .clk          (clk),
  .arst_n       (arst_n),
  .inst_bus     (inst_bus),
  .inst_rsp     (inst_rsp),
  .fetch_bundle (fetch_bundle)
);

// ==== sim/tb_mycpu_mem.sv ====
`timescale 1ns/1ns

module tb_mycpu_mem;

  localparam int          SETS           = 32;
  localparam int          LINE_WORDS     = 4;
  localparam logic [31:0] MEM_KEY        = 32'h5a5a_0f0f; // word = paddr ^ key
  localparam logic [31:0] LAST_OFF       = 32'(4 * (LINE_WORDS - 1)); // last word in a line
  localparam int          FETCHES        = 48; // all tests, squashed and background ones too
  localparam int          WORST_FETCH    = LINE_WORDS * 16 + 8; // slow addr_ok, 3-cycle data_ok
  localparam int          TIMEOUT_CYCLES = FETCHES * WORST_FETCH + 400; // plus fixed waits

  logic                       clk;
  logic                       arst_n;
  logic                       redirect;
  logic [31:0]                redirect_pc;
  logic                       fetch_hold;
  cpu_mem_pkg::fetch_bundle_t fetch_bundle;
  cpu_mem_pkg::mem_req_t      inst_bus;
  cpu_mem_pkg::mem_rsp_t      inst_rsp;
  cpu_mem_pkg::data_req_t     data_in;
  cpu_mem_pkg::mem_req_t      data_bus;
  cpu_mem_pkg::mem_rsp_t      data_rsp;
  cpu_mem_pkg::mem_rsp_t      data_out;

  cpu_mem_pkg::fetch_bundle_t bundles[$]; // seen on the output, oldest first
  logic [31:0]                pend_addr[$];  // accepted inst reads
  int                         pend_ready[$]; // earliest cycle for data_ok
  int                         cycles = 0;
  int                         inst_reads = 0;
  int                         errors = 0;
  int                         checks = 0;
  int                         tests_run = 0;
  int                         tests_failed = 0;
  int                         test_err0 = 0;
  logic [31:0]                exp_pc;

  mycpu_mem #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) u_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .fetch_hold   (fetch_hold),
    .fetch_bundle (fetch_bundle),
    .inst_bus     (inst_bus),
    .inst_rsp     (inst_rsp),
    .data_in      (data_in),
    .data_bus     (data_bus),
    .data_rsp     (data_rsp),
    .data_out     (data_out)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("simulation timed out after %0d cycles with tests unfinished", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // kseg0 and kseg1 both land in the low 512 MB
  function automatic logic [31:0] phys_of(input logic [31:0] va);
    if (va[31:30] == 2'b10)
      return {3'b000, va[28:0]};
    return va;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] pa);
    return {pa[31:2], 2'b00} ^ MEM_KEY;
  endfunction

  // second word only for cached fetches that stay inside the line
  function automatic logic pair_expected(input logic [31:0] va);
    logic [31:0] word;
    word = (va >> 2) % LINE_WORDS;
    return (va[31:29] != 3'b101) && (word != LINE_WORDS - 1);
  endfunction

  // instruction memory, random addr_ok, in-order data 1..3 cycles later
  initial begin : inst_responder
    logic        acc;
    logic        ret;
    logic [31:0] acc_addr;
    inst_rsp = '0;
    forever begin
      @(negedge clk);
      acc      = arst_n & inst_bus.req & inst_rsp.addr_ok;
      ret      = inst_rsp.data_ok;
      acc_addr = inst_bus.addr;
      if (acc) begin
        checks++; // read-only word fetch
        if (inst_bus.wr !== 1'b0 || inst_bus.size !== 2'b10 || inst_bus.wdata !== '0)
          report_error($sformatf("inst_bus read has wr %b, size %0d, wdata %h",
                                 inst_bus.wr, inst_bus.size, inst_bus.wdata));
      end
      @(posedge clk);
      #1;
      if (ret) begin
        void'(pend_addr.pop_front());
        void'(pend_ready.pop_front());
      end
      if (acc) begin
        pend_addr.push_back(acc_addr);
        pend_ready.push_back(cycles + int'($urandom_range(0, 2)));
        inst_reads++;
      end
      inst_rsp.addr_ok = ($urandom_range(0, 3) != 0);
      inst_rsp.data_ok = (pend_addr.size() > 0) && (cycles >= pend_ready[0]);
      inst_rsp.rdata   = inst_rsp.data_ok ? mem_word(pend_addr[0]) : $urandom;
    end
  end

  // valid during a redirect cycle comes from a fetch delivered before it
  always @(negedge clk) begin
    if (arst_n && fetch_bundle.valid && !redirect)
      bundles.push_back(fetch_bundle);
  end

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
      report_error($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  // next bundle against the model, pc moves on to the following fetch
  task automatic check_next(inout logic [31:0] pc);
    cpu_mem_pkg::fetch_bundle_t b;
    logic                       pair;
    while (bundles.size() == 0)
      @(negedge clk);
    b    = bundles.pop_front();
    pair = pair_expected(pc);
    check_val("bundle pc", b.pc, pc);
    check_val("instr_0", b.instr_0, mem_word(phys_of(pc)));
    check_val("pair", 32'(b.pair), 32'(pair));
    if (pair)
      check_val("instr_1", b.instr_1, mem_word(phys_of(pc + 32'd4)));
    pc = pc + (pair ? 32'd8 : 32'd4);
  endtask

  // hold fetch and wait for bus and output to go quiet
  task automatic quiesce();
    int quiet;
    quiet = 0;
    @(posedge clk);
    #1 fetch_hold = 1'b1;
    while (quiet < 4) begin
      @(negedge clk);
      quiet = (inst_bus.req || fetch_bundle.valid || pend_addr.size() > 0) ? 0 : quiet + 1;
    end
  endtask

  task automatic redirect_to(input logic [31:0] pc);
    @(posedge clk);
    #1;
    redirect    = 1'b1;
    redirect_pc = pc;
    bundles.delete(); // older stream
    @(posedge clk);
    #1 redirect = 1'b0;
  endtask

  // hold low for one idle cycle, exactly one fetch issued
  task automatic single_fetch();
    @(posedge clk);
    #1 fetch_hold = 1'b0;
    @(posedge clk);
    #1 fetch_hold = 1'b1;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  initial begin
    int reads0;
    int held0;
    void'($urandom(32'h7882));
    arst_n      = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    fetch_hold  = 1'b0;
    data_in     = '0;
    data_rsp    = '0;
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;

    exp_pc = cpu_mem_pkg::RESET_PC; // kseg1 boot, single words
    repeat (6) check_next(exp_pc);
    end_test("boot_uncached");

    quiesce();
    redirect_to(32'h8000_1004);
    fetch_hold = 1'b0;
    exp_pc     = 32'h8000_1004;
    repeat (8) check_next(exp_pc);
    end_test("cached_pairs");

    quiesce();
    reads0 = inst_reads;
    redirect_to(32'h8000_1000); // line filled by the previous test
    exp_pc = 32'h8000_1000;
    repeat (LINE_WORDS / 2) begin
      single_fetch();
      check_next(exp_pc);
    end
    quiesce();
    check_val("reads on hits", inst_reads - reads0, 0);
    reads0 = inst_reads;
    redirect_to(32'h8000_2040 + LAST_OFF); // new line
    exp_pc = 32'h8000_2040 + LAST_OFF;
    single_fetch();
    check_next(exp_pc);
    quiesce();
    check_val("reads for one refill", inst_reads - reads0, LINE_WORDS);
    end_test("hit_no_traffic");

    redirect_to(32'h8000_5000); // miss, long refill
    fetch_hold = 1'b0;
    while (!inst_bus.req)
      @(negedge clk);
    redirect_to(32'h8000_1008); // lands mid refill
    exp_pc = 32'h8000_1008;
    repeat (4) check_next(exp_pc);
    end_test("redirect_squash");

    @(posedge clk);
    #1 fetch_hold = 1'b1;
    held0 = bundles.size();
    quiesce();
    repeat (20) @(negedge clk);
    checks++;
    if (bundles.size() > held0 + 1)
      report_error($sformatf("%0d bundles arrived under hold", bundles.size() - held0));
    while (bundles.size() > 0)
      check_next(exp_pc);
    @(posedge clk);
    #1 fetch_hold = 1'b0;
    repeat (4) check_next(exp_pc);
    end_test("fetch_hold");

    repeat (24) begin
      @(posedge clk);
      #1;
      data_in.req      = ($urandom_range(0, 1) == 1);
      data_in.wr       = ($urandom_range(0, 1) == 1);
      data_in.size     = 2'($urandom_range(0, 2));
      data_in.addr     = {($urandom_range(0, 1) == 1) ? 3'b101 : 3'b100, 29'($urandom)};
      data_in.wdata    = $urandom;
      data_rsp.rdata   = $urandom;
      data_rsp.addr_ok = ($urandom_range(0, 1) == 1);
      data_rsp.data_ok = ($urandom_range(0, 1) == 1);
      @(negedge clk);
      check_val("data_bus addr", data_bus.addr, phys_of(data_in.addr));
      check_val("data_bus wdata", data_bus.wdata, data_in.wdata);
      check_val("data_bus ctl", 32'({data_bus.req, data_bus.wr, data_bus.size}),
                32'({data_in.req, data_in.wr, data_in.size}));
      checks++;
      if (data_out !== data_rsp)
        report_error($sformatf("data_out %h, expected %h", data_out, data_rsp));
    end
    end_test("data_path");

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
